/* common/usbdev_link_pkg.sv */
package usbdev_link_pkg;

	// link states of the device as software sees them.
	typedef enum logic [2:0] {
		LinkDisconnect     = 3'd0,
		LinkPowered        = 3'd1,
		LinkPoweredSuspend = 3'd2,
		LinkActive         = 3'd3,
		LinkSuspend        = 3'd4
	} link_state_e;

	localparam int NumIntr = 6;

	localparam int IntrDisconnect = 0;
	localparam int IntrConnect    = 1;
	localparam int IntrReset      = 2;
	localparam int IntrSuspend    = 3;
	localparam int IntrResume     = 4;
	localparam int IntrHostLost   = 5;

endpackage

/* common/usbdev_timing_pkg.sv */
package usbdev_timing_pkg;

	localparam int TickDiv  = 48; // 48 MHz clocks per microsecond.
	localparam int TickCntW = $clog2(TickDiv);

	// samples a line level must agree on before it is believed.
	localparam int FilterCycles = 6;

	// se0 longer than ResetTimeout+1 microseconds is a bus reset.
	localparam logic [2:0] ResetTimeout = 3'd3;

	localparam logic [11:0] SuspendTimeout = 12'd3000; // idle microseconds before suspend.

	// bit 12 of the host timer sets after 4096 us without an SOF.
	localparam int HostLostBit = 12;

endpackage

/* src/prim_filter.sv */
`timescale 1ns/10ps

module prim_filter #(
	parameter int Cycles = 4
) (
	input  logic clk_48mhz_i,
	input  logic rst_ni,
	input  logic filter_i,
	output logic filter_o
);

	logic [Cycles-1:0] stage_q;
	logic              out_q;

	always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
		if (!rst_ni) begin
			stage_q <= '0;
		end else begin
			stage_q <= {stage_q[Cycles-2:0], filter_i};
		end
	end

	// the output only moves once the whole history agrees.
	always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
		if (!rst_ni) begin
			out_q <= 1'b0;
		end else if (&stage_q) begin
			out_q <= 1'b1;
		end else if (~|stage_q) begin
			out_q <= 1'b0;
		end
	end

	assign filter_o = out_q;

endmodule

/* src/usbdev_us_tick.sv */
`timescale 1ns/10ps

module usbdev_us_tick import usbdev_timing_pkg::*; (
	input  logic clk_48mhz_i,
	input  logic rst_ni,
	output logic us_tick_o
);

	logic [TickCntW-1:0] cnt_q;
	logic                tick_q;
	logic                wrap;

	assign wrap = (cnt_q == TickCntW'(TickDiv - 1));

	always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
		if (!rst_ni) begin
			cnt_q  <= '0;
			tick_q <= 1'b0;
		end else begin
			cnt_q  <= wrap ? '0 : cnt_q + 1'b1;
			tick_q <= wrap; // registered, so the first tick lands TickDiv clocks out.
		end
	end

	assign us_tick_o = tick_q;

endmodule

/* usbdev_linkstate/usbdev_linkstate.sv */
`timescale 1ns/10ps

module usbdev_linkstate import usbdev_link_pkg::*, usbdev_timing_pkg::*; (
	input  logic        clk_48mhz_i,
	input  logic        rst_ni,
	input  logic        us_tick_i,
	input  logic        usb_sense_i,
	input  logic        usb_rx_d_i,
	input  logic        usb_rx_se0_i,
	input  logic        sof_valid_i,
	output logic        link_disconnect_o,
	output logic        link_connect_o,
	output logic        link_reset_o,
	output logic        link_suspend_o,
	output logic        link_resume_o,
	output logic        host_lost_o,
	output link_state_e link_state_o
);

	typedef enum logic [1:0] {
		RstNone,
		RstCnt,
		RstPend
	} rst_state_e;

	typedef enum logic [1:0] {
		InacWatch,
		InacCnt,
		InacPend
	} inac_state_e;

	link_state_e link_state_d, link_state_q;
	rst_state_e  rst_state_d, rst_state_q;
	inac_state_e inac_state_d, inac_state_q;

	logic [2:0]           rst_timer_d, rst_timer_q;
	logic [11:0]          inac_timer_d, inac_timer_q;
	logic [HostLostBit:0] host_timer_q;

	logic see_se0;
	logic see_idle;
	logic see_pwr_sense;
	logic line_idle_raw;
	logic monitor_inac;
	logic ev_reset;
	logic ev_bus_inactive;
	logic ev_bus_active;

	assign line_idle_raw = usb_rx_d_i & ~usb_rx_se0_i; // idle J on the line.

	prim_filter #(.Cycles(FilterCycles)) u_filter_se0 (
		.clk_48mhz_i(clk_48mhz_i),
		.rst_ni     (rst_ni),
		.filter_i   (usb_rx_se0_i),
		.filter_o   (see_se0)
	);

	prim_filter #(.Cycles(FilterCycles)) u_filter_idle (
		.clk_48mhz_i(clk_48mhz_i),
		.rst_ni     (rst_ni),
		.filter_i   (line_idle_raw),
		.filter_o   (see_idle)
	);

	prim_filter #(.Cycles(FilterCycles)) u_filter_sense (
		.clk_48mhz_i(clk_48mhz_i),
		.rst_ni     (rst_ni),
		.filter_i   (usb_sense_i),
		.filter_o   (see_pwr_sense)
	);

	assign ev_bus_active = ~see_idle;
	assign monitor_inac  = see_pwr_sense &
		((link_state_q == LinkPowered) | (link_state_q == LinkActive));

	always_comb begin
		link_state_d  = link_state_q;
		link_resume_o = 1'b0;
		if (!see_pwr_sense) begin
			link_state_d = LinkDisconnect;
		end else begin
			unique case (link_state_q)
				LinkDisconnect: link_state_d = LinkPowered;
				LinkPowered: begin
					if (ev_reset) begin
						link_state_d = LinkActive;
					end else if (ev_bus_inactive) begin
						link_state_d = LinkPoweredSuspend;
					end
				end
				LinkPoweredSuspend: begin
					if (ev_reset) begin
						link_state_d  = LinkActive;
						link_resume_o = 1'b1;
					end else if (ev_bus_active) begin
						link_state_d  = LinkPowered;
						link_resume_o = 1'b1;
					end
				end
				LinkActive: begin
					if (ev_bus_inactive) begin
						link_state_d = LinkSuspend;
					end
				end
				LinkSuspend: begin
					if (ev_reset || ev_bus_active) begin
						link_state_d  = LinkActive;
						link_resume_o = 1'b1;
					end
				end
				default: link_state_d = LinkDisconnect;
			endcase
		end
	end

	// the reset detector times se0 in microseconds and fires when it ends.
	always_comb begin
		rst_state_d  = rst_state_q;
		rst_timer_d  = rst_timer_q;
		ev_reset     = 1'b0;
		link_reset_o = (rst_state_q == RstPend);
		unique case (rst_state_q)
			RstNone: begin
				rst_timer_d = '0;
				if (see_se0) rst_state_d = RstCnt;
			end
			RstCnt: begin
				if (!see_se0) begin
					rst_state_d = RstNone;
				end else if (us_tick_i) begin
					if (rst_timer_q == ResetTimeout) rst_state_d = RstPend;
					else rst_timer_d = rst_timer_q + 1'b1;
				end
			end
			RstPend: begin
				if (!see_se0) begin
					rst_state_d = RstNone;
					ev_reset    = 1'b1;
				end
			end
			default: rst_state_d = RstNone;
		endcase
	end

	// the inactivity detector is only armed in powered or active.
	always_comb begin
		inac_state_d    = inac_state_q;
		inac_timer_d    = inac_timer_q;
		ev_bus_inactive = 1'b0;
		unique case (inac_state_q)
			InacWatch: begin
				inac_timer_d = '0;
				if (see_idle && monitor_inac) inac_state_d = InacCnt;
			end
			InacCnt: begin
				if (!see_idle || !monitor_inac) begin
					inac_state_d = InacWatch;
				end else if (us_tick_i) begin
					if (inac_timer_q == SuspendTimeout) begin
						inac_state_d    = InacPend;
						ev_bus_inactive = 1'b1;
					end else begin
						inac_timer_d = inac_timer_q + 1'b1;
					end
				end
			end
			InacPend: if (!see_idle || !monitor_inac) inac_state_d = InacWatch;
			default: inac_state_d = InacWatch;
		endcase
	end

	always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
		if (!rst_ni) begin
			link_state_q <= LinkDisconnect;
			rst_state_q  <= RstNone;
			rst_timer_q  <= '0;
			inac_state_q <= InacWatch;
			inac_timer_q <= '0;
		end else begin
			link_state_q <= link_state_d;
			rst_state_q  <= rst_state_d;
			rst_timer_q  <= rst_timer_d;
			inac_state_q <= inac_state_d;
			inac_timer_q <= inac_timer_d;
		end
	end

	// the host presence timer saturates once the top bit is set.
	// it clears on the same edge that leaves active.
	always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
		if (!rst_ni) begin
			host_timer_q <= '0;
		end else if (sof_valid_i || link_state_d != LinkActive || link_reset_o) begin
			host_timer_q <= '0;
		end else if (us_tick_i && !host_lost_o) begin
			host_timer_q <= host_timer_q + 1'b1;
		end
	end

	assign host_lost_o       = host_timer_q[HostLostBit];
	assign link_disconnect_o = (link_state_q == LinkDisconnect);
	assign link_connect_o    = (link_state_q != LinkDisconnect);
	assign link_suspend_o    = (link_state_q == LinkSuspend) |
		(link_state_q == LinkPoweredSuspend);
	assign link_state_o      = link_state_q;

endmodule

/* src/usbdev_link_events.sv */
`timescale 1ns/10ps

module usbdev_link_events import usbdev_link_pkg::*; (
	input  logic               clk_48mhz_i,
	input  logic               rst_ni,
	input  logic               link_disconnect_i,
	input  logic               link_connect_i,
	input  logic               link_reset_i,
	input  logic               link_suspend_i,
	input  logic               link_resume_i,
	input  logic               host_lost_i,
	input  logic [NumIntr-1:0] intr_clear_i,
	output logic [NumIntr-1:0] intr_state_o
);

	logic [NumIntr-1:0] lvl, lvl_q;
	logic [NumIntr-1:0] event_set;
	logic [NumIntr-1:0] intr_q;

	always_comb begin
		lvl                 = '0;
		lvl[IntrDisconnect] = link_disconnect_i;
		lvl[IntrConnect]    = link_connect_i;
		lvl[IntrReset]      = link_reset_i;
		lvl[IntrSuspend]    = link_suspend_i;
		lvl[IntrHostLost]   = host_lost_i;
		event_set             = lvl & ~lvl_q;
		event_set[IntrResume] = link_resume_i; // already a single-cycle pulse.
	end

	always_ff @(posedge clk_48mhz_i or negedge rst_ni) begin
		if (!rst_ni) begin
			lvl_q                 <= '0;
			lvl_q[IntrDisconnect] <= 1'b1; // the link comes out of reset disconnected.
			intr_q                <= '0;
		end else begin
			lvl_q  <= lvl;
			intr_q <= (intr_q & ~intr_clear_i) | event_set; // a new event beats a clear.
		end
	end

	assign intr_state_o = intr_q;

endmodule

/* src/usbdev_link_top.sv */
`timescale 1ns/10ps

module usbdev_link_top import usbdev_link_pkg::*; (
	input  logic               clk_48mhz_i,
	input  logic               rst_ni,
	input  logic               usb_sense_i,
	input  logic               usb_rx_d_i,
	input  logic               usb_rx_se0_i,
	input  logic               sof_valid_i,
	input  logic [NumIntr-1:0] intr_clear_i,
	output link_state_e        link_state_o,
	output logic               link_reset_o,
	output logic               link_suspend_o,
	output logic               host_lost_o,
	output logic [NumIntr-1:0] intr_state_o
);

	logic us_tick;
	logic link_disconnect;
	logic link_connect;
	logic link_resume;

	usbdev_us_tick u_us_tick (
		.clk_48mhz_i(clk_48mhz_i),
		.rst_ni     (rst_ni),
		.us_tick_o  (us_tick)
	);

	usbdev_linkstate u_linkstate (
		.clk_48mhz_i      (clk_48mhz_i),
		.rst_ni           (rst_ni),
		.us_tick_i        (us_tick),
		.usb_sense_i      (usb_sense_i),
		.usb_rx_d_i       (usb_rx_d_i),
		.usb_rx_se0_i     (usb_rx_se0_i),
		.sof_valid_i      (sof_valid_i),
		.link_disconnect_o(link_disconnect),
		.link_connect_o   (link_connect),
		.link_reset_o     (link_reset_o),
		.link_suspend_o   (link_suspend_o),
		.link_resume_o    (link_resume),
		.host_lost_o      (host_lost_o),
		.link_state_o     (link_state_o)
	);

	usbdev_link_events u_link_events (
		.clk_48mhz_i      (clk_48mhz_i),
		.rst_ni           (rst_ni),
		.link_disconnect_i(link_disconnect),
		.link_connect_i   (link_connect),
		.link_reset_i     (link_reset_o),
		.link_suspend_i   (link_suspend_o),
		.link_resume_i    (link_resume),
		.host_lost_i      (host_lost_o),
		.intr_clear_i     (intr_clear_i),
		.intr_state_o     (intr_state_o)
	);

endmodule

/* tests/tb_clkgen.sv */
`timescale 1ns/10ps

module tb_clkgen (
	output logic clk_o,
	output logic rst_n_o
);

	initial begin
		clk_o   = 1'b0;
		rst_n_o = 1'b0;
		repeat (10) @(posedge clk_o);
		#1 rst_n_o = 1'b1; // released just after an edge, ahead of the stimulus drive point.
	end

	always #20 clk_o = ~clk_o; // 40 ns period.

endmodule

/* tests/usbdev_link_sva.sv */
`timescale 1ns/10ps

module usbdev_link_sva import usbdev_link_pkg::*; (
	input logic               clk_48mhz_i,
	input logic               rst_ni,
	input link_state_e        link_state_i,
	input logic               link_disconnect_i,
	input logic               link_connect_i,
	input logic               link_reset_i,
	input logic               link_suspend_i,
	input logic               link_resume_i,
	input logic               host_lost_i,
	input logic [NumIntr-1:0] intr_clear_i,
	input logic [NumIntr-1:0] intr_state_i
);

	int assert_fails = 0;

	logic [NumIntr-1:0] lvl;

	always_comb begin
		lvl                 = '0;
		lvl[IntrDisconnect] = link_disconnect_i;
		lvl[IntrConnect]    = link_connect_i;
		lvl[IntrReset]      = link_reset_i;
		lvl[IntrSuspend]    = link_suspend_i;
		lvl[IntrHostLost]   = host_lost_i;
	end

	a_legal_state: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
		link_state_i inside {LinkDisconnect, LinkPowered, LinkPoweredSuspend,
			LinkActive, LinkSuspend})
		else begin
			$error("link state holds an illegal encoding 0x%0h", link_state_i);
			assert_fails++;
		end

	a_lost_active: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
		host_lost_i |-> link_state_i == LinkActive)
		else begin
			$error("host lost is reported outside the active state");
			assert_fails++;
		end

	a_suspend_lvl: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
		link_suspend_i == (link_state_i inside {LinkSuspend, LinkPoweredSuspend}))
		else begin
			$error("suspend output disagrees with the link state");
			assert_fails++;
		end

	a_resume_intr: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
		link_resume_i |=> intr_state_i[IntrResume])
		else begin
			$error("resume pulse did not set its interrupt bit");
			assert_fails++;
		end

	// a clear only takes effect when no new event lands on the same bit.
	for (genvar i = 0; i < NumIntr; i++) begin : g_clear
		a_clear: assert property (@(posedge clk_48mhz_i) disable iff (!rst_ni)
			intr_clear_i[i] && !$rose(lvl[i]) && !(i == IntrResume && link_resume_i)
			|=> !intr_state_i[i])
			else begin
				$error("interrupt bit %0d is still set after a clear", i);
				assert_fails++;
			end
	end

endmodule

/* tests/usbdev_link_tb.sv */
`timescale 1ns/10ps

module usbdev_link_tb
	import usbdev_link_pkg::*, usbdev_timing_pkg::*;
();

	logic               clk;
	logic               rst_n;
	logic               usb_sense;
	logic               usb_rx_d;
	logic               usb_rx_se0;
	logic               sof_valid;
	logic [NumIntr-1:0] intr_clear;
	link_state_e        link_state;
	logic               link_reset;
	logic               link_suspend;
	logic               host_lost;
	logic [NumIntr-1:0] intr_state;

	int seed = 4132;
	int errors = 0;
	int timeouts = 0;
	bit flag;

	tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

	usbdev_link_top UUT (
		.clk_48mhz_i   (clk),
		.rst_ni        (rst_n),
		.usb_sense_i   (usb_sense),
		.usb_rx_d_i    (usb_rx_d),
		.usb_rx_se0_i  (usb_rx_se0),
		.sof_valid_i   (sof_valid),
		.intr_clear_i  (intr_clear),
		.link_state_o  (link_state),
		.link_reset_o  (link_reset),
		.link_suspend_o(link_suspend),
		.host_lost_o   (host_lost),
		.intr_state_o  (intr_state)
	);

	bind usbdev_link_top usbdev_link_sva u_sva (
		.clk_48mhz_i      (clk_48mhz_i),
		.rst_ni           (rst_ni),
		.link_state_i     (link_state_o),
		.link_disconnect_i(link_disconnect),
		.link_connect_i   (link_connect),
		.link_reset_i     (link_reset_o),
		.link_suspend_i   (link_suspend_o),
		.link_resume_i    (link_resume),
		.host_lost_i      (host_lost_o),
		.intr_clear_i     (intr_clear_i),
		.intr_state_i     (intr_state_o)
	);

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic wait_state(input link_state_e want, input int max_clocks);
		int n;
		n = 0;
		while (link_state != want && n < max_clocks) begin
			step();
			n++;
		end
		if (link_state != want) begin
			$display("timeout: link state did not reach %0d within %0d clocks", want, max_clocks);
			timeouts++;
		end
	endtask

	task automatic clear_intr(input logic [NumIntr-1:0] mask);
		intr_clear = mask;
		step();
		intr_clear = '0;
	endtask

	// random J/K runs; without SOF it stops as soon as the host is reported lost.
	task automatic run_traffic(input int clocks, input bit with_sof, output bit lost_seen);
		int n;
		int run_left;
		int sof_left;
		n         = 0;
		run_left  = 1;
		sof_left  = TickDiv * (500 + rand_below(3499));
		lost_seen = 1'b0;
		while (n < clocks && !(!with_sof && host_lost)) begin
			run_left--;
			if (run_left == 0) begin
				usb_rx_d = ~usb_rx_d;
				run_left = usb_rx_d ? 8 + rand_below(256) : 8 + rand_below(32);
			end
			sof_valid = 1'b0;
			if (with_sof) begin
				sof_left--;
				if (sof_left == 0) begin
					sof_valid = 1'b1;
					sof_left  = TickDiv * (500 + rand_below(3499)); // always under 4000 us.
				end
			end
			step();
			lost_seen |= host_lost;
			n++;
		end
		sof_valid = 1'b0;
		usb_rx_d  = 1'b1;
	endtask

	initial begin
		int n;
		usb_sense  = 1'b0;
		usb_rx_d   = 1'b1;
		usb_rx_se0 = 1'b0;
		sof_valid  = 1'b0;
		intr_clear = '0;
		n = 0;
		while (!rst_n && n < 40) begin
			step();
			n++;
		end
		if (!rst_n) begin
			$display("timeout: reset was never released");
			timeouts++;
		end
		check("link_state_o", link_state, LinkDisconnect);
		check("intr_state_o", intr_state, '0);

		usb_sense = 1'b1;
		wait_state(LinkPowered, 50);
		step();
		check("intr_state_o[IntrConnect]", intr_state[IntrConnect], 1'b1);
		usb_sense = 1'b0; // shorter than the filter length.
		repeat (FilterCycles - 3) step();
		usb_sense = 1'b1;
		repeat (20) begin
			step();
			check("link_state_o", link_state, LinkPowered);
		end

		usb_rx_se0 = 1'b1;
		usb_rx_d   = 1'b0;
		repeat (10 * TickDiv) step();
		check("link_reset_o", link_reset, 1'b1);
		check("intr_state_o[IntrReset]", intr_state[IntrReset], 1'b1);
		usb_rx_se0 = 1'b0;
		usb_rx_d   = 1'b1;
		wait_state(LinkActive, 50);
		check("link_reset_o", link_reset, 1'b0);
		clear_intr(NumIntr'(1) << IntrReset);
		check("intr_state_o[IntrReset]", intr_state[IntrReset], 1'b0);

		usb_rx_se0 = 1'b1; // 2 us of se0 is too short for a bus reset.
		usb_rx_d   = 1'b0;
		flag       = 1'b0;
		repeat (2 * TickDiv) begin
			step();
			flag |= link_reset;
		end
		usb_rx_se0 = 1'b0;
		usb_rx_d   = 1'b1;
		repeat (20) step();
		check("link_reset_o", flag, 1'b0);
		check("link_state_o", link_state, LinkActive);
		check("intr_state_o[IntrReset]", intr_state[IntrReset], 1'b0);

		wait_state(LinkSuspend, 3100 * TickDiv);
		check("link_suspend_o", link_suspend, 1'b1);
		step();
		check("intr_state_o[IntrSuspend]", intr_state[IntrSuspend], 1'b1);
		usb_rx_d = 1'b0;
		wait_state(LinkActive, 50);
		step();
		check("intr_state_o[IntrResume]", intr_state[IntrResume], 1'b1);
		usb_rx_d = 1'b1;

		run_traffic(4100 * TickDiv, 1'b0, flag);
		if (!host_lost) begin
			$display("timeout: host_lost_o did not rise within 4100 us");
			timeouts++;
		end
		step();
		check("intr_state_o[IntrHostLost]", intr_state[IntrHostLost], 1'b1);
		sof_valid = 1'b1;
		step();
		sof_valid = 1'b0;
		step();
		check("host_lost_o", host_lost, 1'b0);
		run_traffic(8000 * TickDiv, 1'b1, flag);
		check("host_lost_o", flag, 1'b0);

		usb_sense = 1'b0;
		wait_state(LinkDisconnect, 50);
		step();
		check("intr_state_o[IntrDisconnect]", intr_state[IntrDisconnect], 1'b1);
		clear_intr('1);
		check("intr_state_o", intr_state, '0);
		step();

		$display("errors: %0d value checks, %0d timeouts, %0d assertion failures",
			errors, timeouts, UUT.u_sva.assert_fails);
		if (errors + timeouts + UUT.u_sva.assert_fails == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* project.f */
common/usbdev_link_pkg.sv
common/usbdev_timing_pkg.sv
src/prim_filter.sv
src/usbdev_us_tick.sv
usbdev_linkstate/usbdev_linkstate.sv
src/usbdev_link_events.sv
src/usbdev_link_top.sv
tests/tb_clkgen.sv
tests/usbdev_link_sva.sv
tests/usbdev_link_tb.sv
